/* src/bit_diff_pkg.sv */
`default_nettype none

package bit_diff_pkg;

   // number of bits in each input word
   localparam int DATA_WIDTH = 16;

   // the difference ranges from -DATA_WIDTH when every bit is zero up to
   // +DATA_WIDTH when every bit is one, so it needs room for 2*DATA_WIDTH+1 values
   localparam int DIFF_WIDTH = $clog2(2*DATA_WIDTH + 1);

   // enough bits to index every bit position of a word
   localparam int COUNT_WIDTH = $clog2(DATA_WIDTH);

   typedef logic [DATA_WIDTH-1:0]         data_t;
   typedef logic signed [DIFF_WIDTH-1:0]  diff_t;
   typedef logic [COUNT_WIDTH-1:0]        count_t;

   // position of the final bit in the scan
   localparam count_t LAST_COUNT = count_t'(DATA_WIDTH - 1);

endpackage

`default_nettype wire

/* src/bit_diff_ctrl_pkg.sv */
`default_nettype none

package bit_diff_ctrl_pkg;

   // START waits for the first go after reset
   // COMPUTE scans one bit per cycle
   // RESTART holds done high and waits for the next go
   typedef enum logic [1:0] {
      START,
      COMPUTE,
      RESTART
   } state_t;

endpackage

`default_nettype wire

/* src/data_shifter.sv */
`default_nettype none

// holds the word under test and shifts it toward bit zero so that the
// accumulator only ever has to look at one fixed bit
module data_shifter (
   input  var logic                clk,
   input  var logic                rst,
   input  var bit_diff_pkg::data_t data,
   input  var logic                data_load,
   input  var logic                data_en,
   output logic                    data_lsb
);

   import bit_diff_pkg::*;

   data_t data_r;
   data_t data_next;

   // select between a fresh word and the shifted copy of the current one
   // zeros fill in from the top but are never examined
   always_comb begin
      if (data_load) begin
         data_next = data;
      end else begin
         data_next = data_r >> 1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_r <= '0;
      end else if (data_en) begin
         data_r <= data_next;
      end
   end

   // the bit that the accumulator consumes this cycle
   assign data_lsb = data_r[0];

endmodule

`default_nettype wire

/* src/bit_counter.sv */
`default_nettype none

// counts how many bits of the word have been consumed
// the controller uses last_bit to know when the scan ends
module bit_counter (
   input  var logic clk,
   input  var logic rst,
   input  var logic count_clear,
   input  var logic count_en,
   output logic     last_bit
);

   import bit_diff_pkg::*;

   count_t count_r;
   count_t count_next;

   // a clear selects zero as the next count, otherwise the count steps up by one
   always_comb begin
      if (count_clear) begin
         count_next = '0;
      end else begin
         count_next = count_r + count_t'(1);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_r <= '0;
      end else if (count_en) begin
         count_r <= count_next;
      end
   end

   // compare the registered count against a constant
   // checking count_next instead would put the incrementer in front of the
   // comparator and would also need one more count bit
   assign last_bit = (count_r == LAST_COUNT);

endmodule

`default_nettype wire

/* src/diff_accumulator.sv */
`default_nettype none

// keeps the running count of ones minus zeros and the last finished result
module diff_accumulator (
   input  var logic           clk,
   input  var logic           rst,
   input  var logic           data_lsb,
   input  var logic           diff_clear,
   input  var logic           diff_en,
   input  var logic           result_en,
   output bit_diff_pkg::diff_t result
);

   import bit_diff_pkg::*;

   diff_t diff_r;
   diff_t result_r;

   // step is +1 for a one bit and -1 for a zero bit
   diff_t diff_step;
   diff_t diff_sum;
   diff_t diff_next;

   assign diff_step = data_lsb ? diff_t'(1) : diff_t'(-1);

   // the sum never leaves the range of diff_t because at most DATA_WIDTH
   // steps are taken from zero before the next clear
   assign diff_sum = diff_r + diff_step;

   // clear wins over the update
   always_comb begin
      if (diff_clear) begin
         diff_next = '0;
      end else begin
         diff_next = diff_sum;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         diff_r <= '0;
      end else if (diff_en) begin
         diff_r <= diff_next;
      end
   end

   // the result register shares diff_next with the running register
   // so the contribution of the final bit lands in result on the same edge
   // and done can be raised in the very next cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_r <= '0;
      end else if (result_en) begin
         result_r <= diff_next;
      end
   end

   // result is held between computations
   assign result = result_r;

endmodule

`default_nettype wire

/* src/bit_diff_ctrl.sv */
`default_nettype none

// controller for the bit-difference datapath
// every output is decoded from the current state and the inputs
module bit_diff_ctrl (
   input  var logic clk,
   input  var logic rst,
   input  var logic go,
   input  var logic last_bit,
   output logic     done,
   output logic     data_load,
   output logic     data_en,
   output logic     count_clear,
   output logic     count_en,
   output logic     diff_clear,
   output logic     diff_en,
   output logic     result_en
);

   import bit_diff_ctrl_pkg::*;

   state_t state_r;
   state_t next_state;

   // state register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_r <= START;
      end else begin
         state_r <= next_state;
      end
   end

   // next state and strobe decode
   always_comb begin
      // stay put and leave every strobe low unless a state says otherwise
      next_state  = state_r;
      done        = 1'b0;
      data_load   = 1'b0;
      data_en     = 1'b0;
      count_clear = 1'b0;
      count_en    = 1'b0;
      diff_clear  = 1'b0;
      diff_en     = 1'b0;
      result_en   = 1'b0;

      case (state_r)
         START : begin
            // keep the datapath primed while idle
            // the word present on the go edge is the one that gets scanned
            data_load   = 1'b1;
            data_en     = 1'b1;
            count_clear = 1'b1;
            count_en    = 1'b1;
            diff_clear  = 1'b1;
            diff_en     = 1'b1;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         COMPUTE : begin
            // shift, count and accumulate one bit per cycle
            // go is deliberately not looked at here
            data_en  = 1'b1;
            count_en = 1'b1;
            diff_en  = 1'b1;
            if (last_bit) begin
               // capture the final sum including this bit
               result_en  = 1'b1;
               next_state = RESTART;
            end
         end

         RESTART : begin
            // same priming as START but with done raised
            // done drops one cycle after go is accepted, not in the same cycle,
            // so logic driving go from done cannot form a combinational loop
            done        = 1'b1;
            data_load   = 1'b1;
            data_en     = 1'b1;
            count_clear = 1'b1;
            count_en    = 1'b1;
            diff_clear  = 1'b1;
            diff_en     = 1'b1;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         default : begin
            // unused encoding, head back to idle
            next_state = START;
         end
      endcase
   end

endmodule

`default_nettype wire

/* src/bit_diff_top.sv */
`default_nettype none

// bit-difference calculator
// after a go pulse the result is the number of one bits minus the number
// of zero bits in the captured word, and done stays high until the next go
module bit_diff_top (
   input  var logic                clk,
   input  var logic                rst,
   input  var logic                go,
   input  var bit_diff_pkg::data_t data,
   output bit_diff_pkg::diff_t     result,
   output logic                    done
);

   // strobes from the controller to the datapath
   logic data_load;
   logic data_en;
   logic count_clear;
   logic count_en;
   logic diff_clear;
   logic diff_en;
   logic result_en;

   // status back from the datapath
   logic data_lsb;
   logic last_bit;

   bit_diff_ctrl bit_diff_ctrl_inst (
      .clk         (clk),
      .rst         (rst),
      .go          (go),
      .last_bit    (last_bit),
      .done        (done),
      .data_load   (data_load),
      .data_en     (data_en),
      .count_clear (count_clear),
      .count_en    (count_en),
      .diff_clear  (diff_clear),
      .diff_en     (diff_en),
      .result_en   (result_en)
   );

   // word register and shifter
   data_shifter data_shifter_inst (
      .clk       (clk),
      .rst       (rst),
      .data      (data),
      .data_load (data_load),
      .data_en   (data_en),
      .data_lsb  (data_lsb)
   );

   // bit position counter
   bit_counter bit_counter_inst (
      .clk         (clk),
      .rst         (rst),
      .count_clear (count_clear),
      .count_en    (count_en),
      .last_bit    (last_bit)
   );

   // running difference and the result register
   diff_accumulator diff_accumulator_inst (
      .clk        (clk),
      .rst        (rst),
      .data_lsb   (data_lsb),
      .diff_clear (diff_clear),
      .diff_en    (diff_en),
      .result_en  (result_en),
      .result     (result)
   );

endmodule

`default_nettype wire

/* sim/bit_diff_tb.sv */
`default_nettype none

// directed testbench for the bit-difference calculator
// inputs change one small delay after each rising edge and outputs are
// sampled at that same point, well away from the edge itself
module bit_diff_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import bit_diff_pkg::*;

   localparam int CLK_HALF     = 2;
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_DELAY  = 1;

   // go is driven, accepted on the next edge, then DATA_WIDTH scan cycles follow
   localparam int RUN_CYCLES = DATA_WIDTH + 1;
   localparam int NUM_RANDOM = 20;

   // fixed words, go during compute, restart checks and the random burst
   localparam int NUM_RUNS     = 4 + 2 + 2 + NUM_RANDOM;
   localparam int TOTAL_CYCLES = RESET_CYCLES + NUM_RUNS * (RUN_CYCLES + 4) + 20;
   localparam int WATCHDOG_MARGIN = 200;

   logic  clk;
   logic  rst;
   logic  go;
   data_t data;
   diff_t result;
   logic  done;

   logic [31:0] lcg_state;

   bit_diff_top bit_diff_top_inst (
      .clk    (clk),
      .rst    (rst),
      .go     (go),
      .data   (data),
      .result (result),
      .done   (done)
   );

   initial begin
      clk = 1'b0;
   end

   always #CLK_HALF clk = ~clk;

   // print the fail message and end the run
   task automatic stop_with_failure();
      $display("Errors found");
      $fatal(1, "simulation stopped after a failure");
   endtask

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      stop_with_failure();
   endtask

   task automatic check_result(input diff_t actual, input diff_t expected, input string what);
      if (actual !== expected) begin
         report_mismatch($sformatf("%s: result %0d, expected %0d", what, actual, expected));
      end
   endtask

   task automatic check_done(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         report_mismatch($sformatf("%s: done %b, expected %b", what, actual, expected));
      end
   endtask

   task automatic check_latency(input int actual, input int expected, input string what);
      if (actual != expected) begin
         report_mismatch($sformatf("%s: done rose after %0d cycles, expected %0d",
                                   what, actual, expected));
      end
   endtask

   // ones minus zeros, counted bit by bit over the whole word
   function automatic diff_t ref_diff(input data_t word);
      int ones;
      int zeros;
      int i;
      ones  = 0;
      zeros = 0;
      for (i = 0; i < DATA_WIDTH; i++) begin
         if (word[i]) begin
            ones++;
         end else begin
            zeros++;
         end
      end
      return diff_t'(ones - zeros);
   endfunction

   // linear congruential generator, upper bits are the better ones
   function automatic data_t random_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return data_t'(lcg_state >> (32 - DATA_WIDTH));
   endfunction

   // starts one computation and waits for done
   // keep_go leaves go high so the next word starts right away
   // disturb scribbles on data and toggles go while the scan runs
   task automatic run_word(input data_t word, input diff_t expected,
                           input bit keep_go, input bit disturb);
      diff_t old_result;
      int    cycles;
      old_result = result;
      cycles     = 0;
      data       = word;
      go         = 1'b1;
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
         cycles++;
         if (!keep_go) begin
            go = 1'b0;
         end
         // these edges all fall inside the scan, where go must be ignored
         if (disturb && cycles < DATA_WIDTH) begin
            data = random_word();
            go   = cycles[0];
         end
         if (cycles == 1) begin
            check_done(done, 1'b0, "one cycle after go was accepted");
         end
         // the previous result stays visible until the new one is captured
         if (!done) begin
            check_result(result, old_result, "result during scan");
         end
         if (!done && cycles >= RUN_CYCLES + 4) begin
            $display("done did not rise within %0d cycles of go for word %h", cycles, word);
            stop_with_failure();
         end
      end while (!done);
      check_latency(cycles, RUN_CYCLES, $sformatf("word %h", word));
      check_result(result, expected, $sformatf("word %h", word));
   endtask

   task automatic test_reset_values();
      check_done(done, 1'b0, "after reset");
      check_result(result, diff_t'(0), "after reset");
   endtask

   // expected values come straight from the word contents
   task automatic test_fixed_words();
      run_word('0, diff_t'(-DATA_WIDTH), 1'b0, 1'b0);
      run_word('1, diff_t'(DATA_WIDTH), 1'b0, 1'b0);
      run_word(data_t'({(DATA_WIDTH/2){2'b10}}), diff_t'(0), 1'b0, 1'b0);
      run_word(data_t'(1), diff_t'(2 - DATA_WIDTH), 1'b0, 1'b0);
   endtask

   task automatic test_go_during_compute();
      data_t word;
      int    n;
      for (n = 0; n < 2; n++) begin
         word = random_word();
         run_word(word, ref_diff(word), 1'b0, 1'b1);
      end
   endtask

   // done holds while idle, falls after go and the old result waits
   task automatic test_restart_holds_result();
      data_t word;
      diff_t held;
      int    n;
      for (n = 0; n < 2; n++) begin
         held = result;
         repeat (3) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_done(done, 1'b1, "idle after a finished word");
            check_result(result, held, "idle after a finished word");
         end
         word = random_word();
         run_word(word, ref_diff(word), 1'b0, 1'b0);
      end
   endtask

   task automatic test_back_to_back();
      data_t word;
      int    n;
      for (n = 0; n < NUM_RANDOM; n++) begin
         word = random_word();
         run_word(word, ref_diff(word), 1'b1, 1'b0);
      end
      // with go dropped the last result and done must stay put
      go = 1'b0;
      word = data;
      @(posedge clk);
      #DRIVE_DELAY;
      check_done(done, 1'b1, "after the last back-to-back word");
      check_result(result, ref_diff(word), "after the last back-to-back word");
   endtask

   // ends a run that stops making progress
   initial begin
      #(TOTAL_CYCLES * CLK_PERIOD + WATCHDOG_MARGIN);
      $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES);
      stop_with_failure();
   end

   initial begin
      lcg_state = 32'ha84e;
      rst  = 1'b1;
      go   = 1'b0;
      data = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      test_reset_values();
      test_fixed_words();
      test_go_during_compute();
      test_restart_holds_result();
      test_back_to_back();

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
src/bit_diff_pkg.sv
src/bit_diff_ctrl_pkg.sv
src/data_shifter.sv
src/bit_counter.sv
src/diff_accumulator.sv
src/bit_diff_ctrl.sv
src/bit_diff_top.sv
sim/bit_diff_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
# a failing check ends the simulation through $fatal, which gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module bit_diff_tb -o bit_diff_sim

./obj_dir/bit_diff_sim
